/* common/color_interp_pkg.sv */
package color_interp_pkg;

  // Screen coordinate width.
  parameter int coord_w = 12;

  // Offset from the origin, 16.16.
  typedef logic signed [31:0] offset_t;

  // Gradient, 16.10.
  typedef logic signed [25:0] grad_fx_t;

  // Start value, 8.10.
  typedef logic [17:0] start_fx_t;

  // Channel sum before the clamp, 10 fraction bits.
  typedef logic signed [19:0] accum_t;

  // Magnitude with the hidden one at bit 23, shifted by the exponent.
  // Bits 22:13 of the result are the 10 kept fraction bits.
  function automatic logic [47:0] float_shift(input logic [31:0] f);
    logic [47:0] mant;
    int          exp_unb;
    mant    = {25'd1, f[22:0]};
    exp_unb = int'(f[30:23]) - 127;
    if (f[30:0] == 31'd0)
    begin
      return '0;
    end
    if (exp_unb < 0)
    begin
      return mant >> (-exp_unb);
    end
    return mant << exp_unb;
  endfunction

  function automatic grad_fx_t float_to_grad_fx(input logic [31:0] f);
    logic [47:0] mag;
    grad_fx_t    val;
    mag = float_shift(f);
    val = mag[38:13];
    if (f[31])
    begin
      val = -val;
    end
    return val;
  endfunction

  function automatic start_fx_t float_to_start_fx(input logic [31:0] f);
    logic [47:0] mag;
    start_fx_t   val;
    mag = float_shift(f);
    val = mag[30:13];
    // Negative starts wrap in two's complement.
    if (f[31])
    begin
      val = -val;
    end
    return val;
  endfunction

endpackage

/* logic/pixel_walker.sv */
`timescale 1ns/1ps

module pixel_walker
  (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic [color_interp_pkg::coord_w-1:0] rect_x0,
    input  logic [color_interp_pkg::coord_w-1:0] rect_y0,
    input  logic [color_interp_pkg::coord_w-1:0] rect_x1,
    input  logic [color_interp_pkg::coord_w-1:0] rect_y1,
    input  color_interp_pkg::offset_t            origin_x,
    input  color_interp_pkg::offset_t            origin_y,
    output logic                                 walk_valid,
    output logic                                 walk_last,
    output logic [color_interp_pkg::coord_w-1:0] walk_x,
    output logic [color_interp_pkg::coord_w-1:0] walk_y,
    output color_interp_pkg::offset_t            walk_dx,
    output color_interp_pkg::offset_t            walk_dy
  );
  import color_interp_pkg::*;

  logic [coord_w-1:0] x0_q;
  logic [coord_w-1:0] x1_q;
  logic [coord_w-1:0] y1_q;
  offset_t            org_x_q;
  offset_t            org_y_q;

  logic               launch;
  logic               advance;
  logic [coord_w-1:0] next_x;
  logic [coord_w-1:0] next_y;
  logic [coord_w-1:0] end_x;
  logic [coord_w-1:0] end_y;
  offset_t            org_x;
  offset_t            org_y;

  // Integer coordinate to 16.16.
  function automatic offset_t coord_to_offset(input logic [coord_w-1:0] c);
    return {{(16 - coord_w){1'b0}}, c, 16'h0000};
  endfunction

  assign launch  = start && !walk_valid;
  assign advance = walk_valid && !walk_last;

  // On launch the first pixel comes straight from the inputs.
  always_comb
  begin
    if (launch)
    begin
      next_x = rect_x0;
      next_y = rect_y0;
      end_x  = rect_x1;
      end_y  = rect_y1;
      org_x  = origin_x;
      org_y  = origin_y;
    end
    else
    begin
      end_x = x1_q;
      end_y = y1_q;
      org_x = org_x_q;
      org_y = org_y_q;
      if (walk_x == x1_q)
      begin
        next_x = x0_q;
        next_y = walk_y + 1'b1;
      end
      else
      begin
        next_x = walk_x + 1'b1;
        next_y = walk_y;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      walk_valid <= 1'b0;
      walk_last  <= 1'b0;
    end
    else if (launch || advance)
    begin
      walk_valid <= 1'b1;
      walk_last  <= (next_x == end_x) && (next_y == end_y);
    end
    else
    begin
      walk_valid <= 1'b0;
      walk_last  <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      x0_q    <= rect_x0;
      x1_q    <= rect_x1;
      y1_q    <= rect_y1;
      org_x_q <= origin_x;
      org_y_q <= origin_y;
    end
    if (launch || advance)
    begin
      walk_x  <= next_x;
      walk_y  <= next_y;
      walk_dx <= coord_to_offset(next_x) - org_x;
      walk_dy <= coord_to_offset(next_y) - org_y;
    end
  end

endmodule

/* color_gen/color_plane_setup.sv */
`timescale 1ns/1ps

module color_plane_setup
  #(
    parameter int num_channels = 4
  )
  (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_planes,
    input  logic [31:0]                    plane_start [num_channels],
    input  logic [31:0]                    plane_dx    [num_channels],
    input  logic [31:0]                    plane_dy    [num_channels],
    output color_interp_pkg::start_fx_t    start_fx    [num_channels],
    output color_interp_pkg::grad_fx_t     grad_x_fx   [num_channels],
    output color_interp_pkg::grad_fx_t     grad_y_fx   [num_channels]
  );
  import color_interp_pkg::*;

  // Float conversion runs once per triangle.
  // The held fixed-point planes feed every pixel of the walk.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_channels; i++)
      begin
        start_fx[i]  <= '0;
        grad_x_fx[i] <= '0;
        grad_y_fx[i] <= '0;
      end
    end
    else if (load_planes)
    begin
      for (int i = 0; i < num_channels; i++)
      begin
        start_fx[i]  <= float_to_start_fx(plane_start[i]);
        grad_x_fx[i] <= float_to_grad_fx(plane_dx[i]);
        grad_y_fx[i] <= float_to_grad_fx(plane_dy[i]);
      end
    end
  end

endmodule

/* color_gen/color_channel_eval.sv */
`timescale 1ns/1ps

module color_channel_eval
  (
    input  logic                        clk,
    input  logic                        reset,
    input  color_interp_pkg::offset_t   walk_dx,
    input  color_interp_pkg::offset_t   walk_dy,
    input  color_interp_pkg::start_fx_t start_fx,
    input  color_interp_pkg::grad_fx_t  grad_x_fx,
    input  color_interp_pkg::grad_fx_t  grad_y_fx,
    output logic [7:0]                  channel_value
  );
  import color_interp_pkg::*;

  // 16.16 times 16.10 leaves 26 fraction bits.
  logic signed [57:0] prod_x;
  logic signed [57:0] prod_y;
  logic signed [57:0] prod_sum;
  accum_t             accum;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      prod_x   <= '0;
      prod_y   <= '0;
      prod_sum <= '0;
      accum    <= '0;
    end
    else
    begin
      prod_x   <= walk_dx * grad_x_fx;
      prod_y   <= walk_dy * grad_y_fx;
      prod_sum <= prod_x + prod_y;
      // Drop 16 fraction bits to line up with the 8.10 start.
      accum    <= prod_sum[35:16] + {2'b00, start_fx};
    end
  end

  // Clamp to a byte.
  always_comb
  begin
    if (accum[19])
    begin
      channel_value = 8'h00;
    end
    else if (accum[18])
    begin
      channel_value = 8'hff;
    end
    else
    begin
      channel_value = accum[17:10];
    end
  end

endmodule

/* logic/pixel_pack.sv */
`timescale 1ns/1ps

module pixel_pack
  #(
    parameter int num_channels = 4
  )
  (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 walk_valid,
    input  logic                                 walk_last,
    input  logic [color_interp_pkg::coord_w-1:0] walk_x,
    input  logic [color_interp_pkg::coord_w-1:0] walk_y,
    input  logic [7:0]                           channel_value [num_channels],
    output logic                                 pix_valid,
    output logic                                 pix_last,
    output logic [color_interp_pkg::coord_w-1:0] pix_x,
    output logic [color_interp_pkg::coord_w-1:0] pix_y,
    output logic [8*num_channels-1:0]            pix_color
  );
  import color_interp_pkg::*;

  // Three stages, matching the channel pipeline.
  logic [2:0]         valid_sr;
  logic [2:0]         last_sr;
  logic [coord_w-1:0] x_sr [3];
  logic [coord_w-1:0] y_sr [3];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_sr <= '0;
      last_sr  <= '0;
    end
    else
    begin
      valid_sr <= {valid_sr[1:0], walk_valid};
      last_sr  <= {last_sr[1:0], walk_last && walk_valid};
    end
  end

  always_ff @(posedge clk)
  begin
    x_sr[0] <= walk_x;
    y_sr[0] <= walk_y;
    for (int i = 1; i < 3; i++)
    begin
      x_sr[i] <= x_sr[i-1];
      y_sr[i] <= y_sr[i-1];
    end
  end

  assign pix_valid = valid_sr[2];
  assign pix_last  = last_sr[2];
  assign pix_x     = x_sr[2];
  assign pix_y     = y_sr[2];

  // Channel 0 in the low byte.
  always_comb
  begin
    for (int i = 0; i < num_channels; i++)
    begin
      pix_color[8*i +: 8] = channel_value[i];
    end
  end

endmodule

/* logic/color_interp_top.sv */
`timescale 1ns/1ps

module color_interp_top
  #(
    parameter int num_channels = 4
  )
  (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 load_planes,
    input  logic [31:0]                          plane_start [num_channels],
    input  logic [31:0]                          plane_dx    [num_channels],
    input  logic [31:0]                          plane_dy    [num_channels],
    input  color_interp_pkg::offset_t            origin_x,
    input  color_interp_pkg::offset_t            origin_y,
    input  logic [color_interp_pkg::coord_w-1:0] rect_x0,
    input  logic [color_interp_pkg::coord_w-1:0] rect_y0,
    input  logic [color_interp_pkg::coord_w-1:0] rect_x1,
    input  logic [color_interp_pkg::coord_w-1:0] rect_y1,
    input  logic                                 start,
    output logic                                 busy,
    output logic                                 pix_valid,
    output logic                                 pix_last,
    output logic [color_interp_pkg::coord_w-1:0] pix_x,
    output logic [color_interp_pkg::coord_w-1:0] pix_y,
    output logic [8*num_channels-1:0]            pix_color
  );
  import color_interp_pkg::*;

  logic               start_go;
  logic               walk_valid;
  logic               walk_last;
  logic [coord_w-1:0] walk_x;
  logic [coord_w-1:0] walk_y;
  offset_t            walk_dx;
  offset_t            walk_dy;
  start_fx_t          start_fx      [num_channels];
  grad_fx_t           grad_x_fx     [num_channels];
  grad_fx_t           grad_y_fx     [num_channels];
  logic [7:0]         channel_value [num_channels];

  // Busy also covers the pixels still draining from the pipeline.
  assign start_go = start && !busy;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy <= 1'b0;
    end
    else if (start_go)
    begin
      busy <= 1'b1;
    end
    else if (pix_last)
    begin
      busy <= 1'b0;
    end
  end

  pixel_walker pixel_walker_i
    (
      .clk        (clk),
      .reset      (reset),
      .start      (start_go),
      .rect_x0    (rect_x0),
      .rect_y0    (rect_y0),
      .rect_x1    (rect_x1),
      .rect_y1    (rect_y1),
      .origin_x   (origin_x),
      .origin_y   (origin_y),
      .walk_valid (walk_valid),
      .walk_last  (walk_last),
      .walk_x     (walk_x),
      .walk_y     (walk_y),
      .walk_dx    (walk_dx),
      .walk_dy    (walk_dy)
    );

  color_plane_setup
    #(
      .num_channels (num_channels)
    )
  color_plane_setup_i
    (
      .clk         (clk),
      .reset       (reset),
      .load_planes (load_planes),
      .plane_start (plane_start),
      .plane_dx    (plane_dx),
      .plane_dy    (plane_dy),
      .start_fx    (start_fx),
      .grad_x_fx   (grad_x_fx),
      .grad_y_fx   (grad_y_fx)
    );

  for (genvar ch = 0; ch < num_channels; ch++)
  begin : gen_channel
    color_channel_eval color_channel_eval_i
      (
        .clk           (clk),
        .reset         (reset),
        .walk_dx       (walk_dx),
        .walk_dy       (walk_dy),
        .start_fx      (start_fx[ch]),
        .grad_x_fx     (grad_x_fx[ch]),
        .grad_y_fx     (grad_y_fx[ch]),
        .channel_value (channel_value[ch])
      );
  end

  pixel_pack
    #(
      .num_channels (num_channels)
    )
  pixel_pack_i
    (
      .clk           (clk),
      .reset         (reset),
      .walk_valid    (walk_valid),
      .walk_last     (walk_last),
      .walk_x        (walk_x),
      .walk_y        (walk_y),
      .channel_value (channel_value),
      .pix_valid     (pix_valid),
      .pix_last      (pix_last),
      .pix_x         (pix_x),
      .pix_y         (pix_y),
      .pix_color     (pix_color)
    );

endmodule

/* tests/color_interp_assertions.sv */
`timescale 1ns/1ps

module color_interp_assertions
  #(
    parameter int num_channels = 4
  )
  (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 load_planes,
    input logic [31:0]                          plane_start [num_channels],
    input logic [31:0]                          plane_dx    [num_channels],
    input logic [31:0]                          plane_dy    [num_channels],
    input color_interp_pkg::offset_t            origin_x,
    input color_interp_pkg::offset_t            origin_y,
    input logic [color_interp_pkg::coord_w-1:0] rect_x0,
    input logic [color_interp_pkg::coord_w-1:0] rect_y0,
    input logic [color_interp_pkg::coord_w-1:0] rect_x1,
    input logic [color_interp_pkg::coord_w-1:0] rect_y1,
    input logic                                 start,
    input logic                                 busy,
    input logic                                 pix_valid,
    input logic                                 pix_last,
    input logic [color_interp_pkg::coord_w-1:0] pix_x,
    input logic [color_interp_pkg::coord_w-1:0] pix_y,
    input logic [8*num_channels-1:0]            pix_color
  );
  import color_interp_pkg::*;

  int fail_count = 0;

  start_fx_t          exp_start [num_channels];
  grad_fx_t           exp_gx    [num_channels];
  grad_fx_t           exp_gy    [num_channels];
  offset_t            org_x;
  offset_t            org_y;
  logic [coord_w-1:0] x0_q;
  logic [coord_w-1:0] x1_q;
  logic [coord_w-1:0] y1_q;
  logic [coord_w-1:0] exp_x;
  logic [coord_w-1:0] exp_y;
  int                 pix_count;
  int                 walk_size;
  logic               accepted;
  logic [8*num_channels-1:0] expected_color;

  assign accepted = start && !busy;

  // Plane value at a pixel, then clamped to a byte.
  function automatic logic [7:0] expected_byte(input int ch, input int x, input int y);
    longint dx;
    longint dy;
    longint sum;
    dx  = (longint'(x) <<< 16) - longint'(org_x);
    dy  = (longint'(y) <<< 16) - longint'(org_y);
    sum = (dx * longint'(exp_gx[ch]) + dy * longint'(exp_gy[ch])) >>> 16;
    sum = sum + longint'(exp_start[ch]);
    if (sum < 0)
    begin
      return 8'h00;
    end
    if (sum >= (256 <<< 10))
    begin
      return 8'hff;
    end
    return 8'(sum >>> 10);
  endfunction

  always_ff @(posedge clk)
  begin
    if (load_planes)
    begin
      for (int i = 0; i < num_channels; i++)
      begin
        exp_start[i] <= float_to_start_fx(plane_start[i]);
        exp_gx[i]    <= float_to_grad_fx(plane_dx[i]);
        exp_gy[i]    <= float_to_grad_fx(plane_dy[i]);
      end
    end
    if (reset)
    begin
      pix_count <= 0;
      walk_size <= 0;
    end
    else if (accepted)
    begin
      org_x     <= origin_x;
      org_y     <= origin_y;
      x0_q      <= rect_x0;
      x1_q      <= rect_x1;
      y1_q      <= rect_y1;
      exp_x     <= rect_x0;
      exp_y     <= rect_y0;
      pix_count <= 0;
      walk_size <= (int'(rect_x1) - int'(rect_x0) + 1) * (int'(rect_y1) - int'(rect_y0) + 1);
    end
    else if (pix_valid)
    begin
      pix_count <= pix_count + 1;
      if (exp_x == x1_q)
      begin
        exp_x <= x0_q;
        exp_y <= exp_y + 1'b1;
      end
      else
      begin
        exp_x <= exp_x + 1'b1;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < num_channels; i++)
    begin
      expected_color[8*i +: 8] = expected_byte(i, int'(exp_x), int'(exp_y));
    end
  end

  a_color: assert property (@(posedge clk) disable iff (reset)
    pix_valid |-> pix_color == expected_color)
    else
    begin
      fail_count++;
      $error("ERROR %0t: wrong pixel color", $time);
    end

  a_order: assert property (@(posedge clk) disable iff (reset)
    pix_valid |-> (pix_x == exp_x) && (pix_y == exp_y))
    else
    begin
      fail_count++;
      $error("ERROR %0t: pixel out of raster order", $time);
    end

  a_last: assert property (@(posedge clk) disable iff (reset)
    pix_valid |-> pix_last == ((pix_x == x1_q) && (pix_y == y1_q)))
    else
    begin
      fail_count++;
      $error("ERROR %0t: wrong last marker", $time);
    end

  a_last_valid: assert property (@(posedge clk) disable iff (reset)
    pix_last |-> pix_valid)
    else
    begin
      fail_count++;
      $error("ERROR %0t: last marker without a pixel", $time);
    end

  a_count: assert property (@(posedge clk) disable iff (reset)
    pix_last |-> pix_count + 1 == walk_size)
    else
    begin
      fail_count++;
      $error("ERROR %0t: wrong pixel count", $time);
    end

  a_first: assert property (@(posedge clk) disable iff (reset)
    (pix_valid && !$past(pix_valid)) |-> $past(start && !busy, 4))
    else
    begin
      fail_count++;
      $error("ERROR %0t: first pixel latency", $time);
    end

  a_reset_idle: assert property (@(posedge clk) disable iff (reset)
    $fell(reset) |-> !busy && !pix_valid && !pix_last)
    else
    begin
      fail_count++;
      $error("ERROR %0t: not idle after reset", $time);
    end

  a_stay_idle: assert property (@(posedge clk) disable iff (reset)
    !busy && !start |=> !busy)
    else
    begin
      fail_count++;
      $error("ERROR %0t: busy rose without a start", $time);
    end

  a_idle: assert property (@(posedge clk) disable iff (reset)
    pix_valid |-> busy)
    else
    begin
      fail_count++;
      $error("ERROR %0t: pixel while idle", $time);
    end

  a_busy_rise: assert property (@(posedge clk) disable iff (reset)
    $past(start && !busy) |-> busy)
    else
    begin
      fail_count++;
      $error("ERROR %0t: busy did not rise", $time);
    end

  a_busy_fall: assert property (@(posedge clk) disable iff (reset)
    $past(pix_last) |-> !busy)
    else
    begin
      fail_count++;
      $error("ERROR %0t: busy did not fall", $time);
    end

endmodule

bind color_interp_top color_interp_assertions
  #(
    .num_channels (num_channels)
  )
assertions_i
  (
    .clk         (clk),
    .reset       (reset),
    .load_planes (load_planes),
    .plane_start (plane_start),
    .plane_dx    (plane_dx),
    .plane_dy    (plane_dy),
    .origin_x    (origin_x),
    .origin_y    (origin_y),
    .rect_x0     (rect_x0),
    .rect_y0     (rect_y0),
    .rect_x1     (rect_x1),
    .rect_y1     (rect_y1),
    .start       (start),
    .busy        (busy),
    .pix_valid   (pix_valid),
    .pix_last    (pix_last),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pix_color   (pix_color)
  );

/* tests/color_interp_tb.sv */
`timescale 1ns/1ps

module color_interp_tb;
  import color_interp_pkg::*;

  localparam int num_channels = 4;
  localparam int num_walks    = 14;

  logic                      clk = 1'b0;
  logic                      reset = 1'b1;
  logic                      load_planes = 1'b0;
  logic [31:0]               plane_start [num_channels];
  logic [31:0]               plane_dx    [num_channels];
  logic [31:0]               plane_dy    [num_channels];
  offset_t                   origin_x = '0;
  offset_t                   origin_y = '0;
  logic [coord_w-1:0]        rect_x0 = '0;
  logic [coord_w-1:0]        rect_y0 = '0;
  logic [coord_w-1:0]        rect_x1 = '0;
  logic [coord_w-1:0]        rect_y1 = '0;
  logic                      start = 1'b0;
  logic                      busy;
  logic                      pix_valid;
  logic                      pix_last;
  logic [coord_w-1:0]        pix_x;
  logic [coord_w-1:0]        pix_y;
  logic [8*num_channels-1:0] pix_color;

  logic [31:0] lfsr = 32'ha42f_fad7;
  int          rect_w [num_walks];
  int          rect_h [num_walks];
  int          total_pixels = 0;
  int          walk_idx = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          errs_before;

  color_interp_top #(.num_channels(num_channels)) color_interp_top_i
    (
      .clk         (clk),
      .reset       (reset),
      .load_planes (load_planes),
      .plane_start (plane_start),
      .plane_dx    (plane_dx),
      .plane_dy    (plane_dy),
      .origin_x    (origin_x),
      .origin_y    (origin_y),
      .rect_x0     (rect_x0),
      .rect_y0     (rect_y0),
      .rect_x1     (rect_x1),
      .rect_y1     (rect_y1),
      .start       (start),
      .busy        (busy),
      .pix_valid   (pix_valid),
      .pix_last    (pix_last),
      .pix_x       (pix_x),
      .pix_y       (pix_y),
      .pix_color   (pix_color)
    );

  initial
  begin
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Value is (1 + m/8) * 2^e.
  function automatic logic [31:0] make_float(input logic sgn, input int e, input logic [2:0] m);
    return {sgn, 8'(127 + e), m, 20'd0};
  endfunction

  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  task automatic load_fixed(input logic [31:0] s, input logic [31:0] gx, input logic [31:0] gy);
    for (int i = 0; i < num_channels; i++)
    begin
      plane_start[i] = s;
      plane_dx[i]    = gx;
      plane_dy[i]    = gy;
    end
    load_planes = 1'b1;
    tick();
    load_planes = 1'b0;
  endtask

  task automatic load_random();
    for (int i = 0; i < num_channels; i++)
    begin
      plane_start[i] = make_float(1'b0, int'(rand_bits(3)), rand_bits(3));
      plane_dx[i]    = make_float(rand_bits(1), int'(rand_bits(3)) % 7 - 4, rand_bits(3));
      plane_dy[i]    = make_float(rand_bits(1), int'(rand_bits(3)) % 7 - 4, rand_bits(3));
    end
    load_planes = 1'b1;
    tick();
    load_planes = 1'b0;
  endtask

  // Origin sits shift pixels right of the rectangle corner.
  task automatic run_walk(input int shift, input bit poke);
    int x0;
    int y0;
    x0       = 16 + int'(rand_bits(4));
    y0       = 8 + int'(rand_bits(4));
    rect_x0  = coord_w'(x0);
    rect_y0  = coord_w'(y0);
    rect_x1  = coord_w'(x0 + rect_w[walk_idx] - 1);
    rect_y1  = coord_w'(y0 + rect_h[walk_idx] - 1);
    origin_x = {16'(x0 + shift), 16'(rand_bits(16))};
    origin_y = {16'(y0 + shift), 16'(rand_bits(16))};
    start    = 1'b1;
    tick();
    start    = 1'b0;
    if (poke)
    begin
      tick();
      rect_x0 = '0;
      rect_x1 = 12'd7;
      start   = 1'b1;
      tick();
      start   = 1'b0;
    end
    while (busy)
    begin
      tick();
    end
    tick();
    walk_idx++;
  endtask

  task automatic report(input int num, input string name);
    if (color_interp_top_i.assertions_i.fail_count == errs_before)
    begin
      $display("test %0d %s: ok", num, name);
      tests_passed++;
    end
    else
    begin
      $display("test %0d %s: FAILED", num, name);
      tests_failed++;
    end
    errs_before = color_interp_top_i.assertions_i.fail_count;
  endtask

  initial
  begin
    wait (total_pixels > 0);
    repeat (total_pixels * 2 + 200) @(posedge clk);
    $display("Run stopped by the watchdog before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    for (int i = 0; i < num_channels; i++)
    begin
      plane_start[i] = '0;
      plane_dx[i]    = '0;
      plane_dy[i]    = '0;
    end
    rect_w[0] = 4;
    rect_h[0] = 3;
    for (int i = 1; i < num_walks; i++)
    begin
      rect_w[i] = 2 + int'(rand_bits(2));
      rect_h[i] = 2 + int'(rand_bits(2));
    end
    for (int i = 0; i < num_walks; i++)
    begin
      total_pixels += rect_w[i] * rect_h[i];
    end
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    errs_before = 0;
    repeat (4) tick();
    report(1, "idle after reset");
    load_fixed(make_float(1'b0, 4, 3'd0), make_float(1'b0, 0, 3'd0), make_float(1'b0, 1, 3'd0));
    run_walk(-1, 1'b0);
    report(2, "raster order");
    for (int i = 0; i < 8; i++)
    begin
      load_random();
      run_walk(int'(rand_bits(2)) - 1, 1'b0);
    end
    report(3, "random planes");
    load_fixed(make_float(1'b0, 7, 3'd7), make_float(1'b0, 4, 3'd0), make_float(1'b0, 4, 3'd0));
    run_walk(-1, 1'b0);
    load_fixed(32'd0, make_float(1'b1, 2, 3'd0), make_float(1'b1, 2, 3'd0));
    run_walk(-1, 1'b0);
    report(4, "clamping");
    load_random();
    run_walk(0, 1'b1);
    report(5, "start while busy");
    load_random();
    run_walk(1, 1'b0);
    load_random();
    run_walk(1, 1'b0);
    report(6, "plane reload");
    $display("%0d tests ok, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* color_interp.f */
common/color_interp_pkg.sv
logic/pixel_walker.sv
color_gen/color_plane_setup.sv
color_gen/color_channel_eval.sv
logic/pixel_pack.sv
logic/color_interp_top.sv
tests/color_interp_assertions.sv
tests/color_interp_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f color_interp.f \
  --top-module color_interp_tb \
  -o color_interp_sim

out=$(./obj_dir/color_interp_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "All tests passed"
